/* sources.f */
+incdir+dv
common/core_pkg.sv
logic/inst_fetch.sv
decode/inst_decode.sv
execute/alu_exec.sv
logic/csr_unit.sv
logic/write_back.sv
logic/rv_core.sv
dv/tb_core.sv

/* Makefile */
sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_core \
		-f sources.f --Mdir obj_dir -o tb_core
	./obj_dir/tb_core

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* dv/ref_model.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// ****************************************************************************
// program memory and generator
// ****************************************************************************
localparam int unsigned MEM_WORDS = 256;
localparam logic [31:0] NOP_WORD  = 32'h0000_0013;  // addi x0, x0, 0

localparam logic [2:0]  ALU_F3   [4] = '{3'b000, 3'b100, 3'b110, 3'b111};
localparam logic [11:0] CSR_PICK [4] = '{CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE, 12'h7c1};

logic [31:0] prog_mem  [MEM_WORDS];
bit          protect_w [MEM_WORDS];  // inside a trap sequence, never a jump target
logic [31:0] lcg_state;

// model state, csr slots are mstatus, mtvec, mepc, mcause
logic [63:0] ref_regs [32];
logic [63:0] ref_csr  [4];
logic [63:0] ref_pc;

function automatic int unsigned rnd(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'd0, lcg_state[31:8]} % n;  // low bits of the lcg are weak
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// any word outside a sequence and other than the jump itself
function automatic int unsigned pick_target(input int unsigned from);
    int unsigned t;
    t = rnd(MEM_WORDS);
    while (protect_w[8'(t)] || t == from) begin
        t = rnd(MEM_WORDS);
    end
    return t;
endfunction

function automatic logic [31:0] random_inst(input int unsigned i);
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int unsigned k;
    rd  = 5'(rnd(31));  // x31 is kept for the trap sequences
    rs1 = 5'(rnd(32));
    rs2 = 5'(rnd(32));
    case (rnd(16))
        0, 1, 2, 3, 4, 5: begin
            word = enc_i(12'(rnd(4096)), rs1, ALU_F3[2'(rnd(4))], rd, OPC_OP_IMM);
        end
        6, 7, 8, 9: begin
            k = rnd(5);
            if (k == 4) begin
                word = {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};  // sub
            end else begin
                word = {7'b0000000, rs2, rs1, ALU_F3[2'(k)], rd, OPC_OP};
            end
        end
        10: word = {20'(rnd(32'h10_0000)), rd, OPC_LUI};
        11: word = enc_j(21'((pick_target(i) - i) * 4), rd);
        12, 13: word = enc_i(CSR_PICK[2'(rnd(4))], rs1, 3'b001, rd, OPC_SYSTEM);
        14: begin
            case (rnd(3))
                0: word = enc_i(12'(rnd(4096)), rs1, 3'b011, rd, 7'b0000011);  // ld
                1: word = enc_i(12'(rnd(4096)), rs1, 3'b010, rd, OPC_OP_IMM);  // slti
                default: word = 32'h0010_0073;                                  // ebreak
            endcase
        end
        default: word = enc_i(12'(rnd(4096)), 5'd0, 3'b000, rd, OPC_OP_IMM);  // li
    endcase
    return word;
endfunction

// trap sequence: jal x31 to next word, addi x31 to the handler, csrrw mtvec, ecall
task automatic fill_program();
    bit          seq_start [MEM_WORDS];
    int unsigned i;
    int unsigned t;
    for (i = 0; i < MEM_WORDS; i++) begin
        seq_start[8'(i)] = 1'b0;
        protect_w[8'(i)] = 1'b0;
    end
    i = 0;
    while (i + 4 < MEM_WORDS) begin
        if (rnd(20) == 0) begin
            seq_start[8'(i)] = 1'b1;
            for (int s = 1; s < 4; s++) begin
                protect_w[8'(i + s)] = 1'b1;
            end
            i += 4;
        end else begin
            i++;
        end
    end
    for (i = 0; i < MEM_WORDS; i++) begin
        if (seq_start[8'(i)]) begin
            t = pick_target(i);
            prog_mem[8'(i)]     = enc_j(21'd4, 5'd31);
            prog_mem[8'(i + 1)] = enc_i(12'((t - i - 1) * 4), 5'd31, 3'b000, 5'd31, OPC_OP_IMM);
            prog_mem[8'(i + 2)] = enc_i(CSR_MTVEC, 5'd31, 3'b001, 5'(rnd(31)), OPC_SYSTEM);
            prog_mem[8'(i + 3)] = 32'h0000_0073;
        end else if (i == MEM_WORDS - 1) begin
            prog_mem[8'(i)] = enc_j(21'((0 - i) * 4), 5'(rnd(31)));  // wrap to the start
        end else if (!protect_w[8'(i)]) begin
            prog_mem[8'(i)] = random_inst(i);
        end
    end
endtask

function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [63:0] offs;
    offs = addr - RESET_PC;
    if (offs < 64'(MEM_WORDS * 4)) begin
        return prog_mem[offs[9:2]];
    end else begin
        return NOP_WORD;
    end
endfunction

// ****************************************************************************
// reference model, one instruction per call
// ****************************************************************************
task automatic reset_model();
    for (int r = 0; r < 32; r++) begin
        ref_regs[5'(r)] = 64'd0;
    end
    for (int c = 0; c < 4; c++) begin
        ref_csr[2'(c)] = 64'd0;
    end
    ref_pc = RESET_PC;
endtask

function automatic logic [2:0] csr_slot(input logic [11:0] addr);
    case (addr)
        CSR_MSTATUS: return 3'd0;
        CSR_MTVEC:   return 3'd1;
        CSR_MEPC:    return 3'd2;
        CSR_MCAUSE:  return 3'd3;
        default:     return 3'd4;  // not implemented
    endcase
endfunction

function automatic retire_t ref_step(input logic [31:0] word, output bit redirect);
    retire_t     exp;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] res;
    logic [63:0] next_pc;
    logic [4:0]  rd;
    logic [2:0]  slot;
    bit          we;
    a        = ref_regs[word[19:15]];  // x0 is never written
    b        = ref_regs[word[24:20]];
    rd       = word[11:7];
    imm      = {{52{word[31]}}, word[31:20]};
    res      = 64'd0;
    we       = 1'b0;
    next_pc  = ref_pc + 64'd4;
    redirect = 1'b0;
    case (word[6:0])
        OPC_OP_IMM: begin
            we = 1'b1;
            case (word[14:12])
                3'b000:  res = a + imm;
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                default: we = 1'b0;
            endcase
        end
        OPC_OP: begin
            we = 1'b1;
            case ({word[31:25], word[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_100: res = a ^ b;
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         we = 1'b0;
            endcase
        end
        OPC_LUI: begin
            we  = 1'b1;
            res = {{32{word[31]}}, word[31:12], 12'b0};
        end
        OPC_JAL: begin
            we       = 1'b1;
            res      = ref_pc + 64'd4;
            next_pc  = ref_pc + {{43{word[31]}}, word[31], word[19:12], word[20],
                                 word[30:21], 1'b0};
            redirect = 1'b1;
        end
        OPC_SYSTEM: begin
            if (word[14:12] == 3'b001) begin  // csrrw, old value to rd
                we   = 1'b1;
                slot = csr_slot(word[31:20]);
                if (slot < 3'd4) begin
                    res                = ref_csr[slot[1:0]];
                    ref_csr[slot[1:0]] = a;
                end
            end else if (word == 32'h0000_0073) begin
                ref_csr[2] = ref_pc;
                ref_csr[3] = 64'd11;
                next_pc    = ref_csr[1];
                redirect   = 1'b1;
            end
        end
        default: ;
    endcase
    exp.valid    = 1'b1;
    exp.pc       = ref_pc;
    exp.inst     = word;
    exp.rd_we    = we && (rd != 5'd0);
    exp.rd       = rd;
    exp.rd_wdata = res;
    if (exp.rd_we) begin
        ref_regs[rd] = res;
    end
    ref_pc = next_pc;
    return exp;
endfunction

`endif

/* dv/tb_core.sv */
module tb_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [63:0] RESET_PC   = 64'h0000_0000_8000_0000;
    localparam int unsigned N_RETIRE   = 2000;
    localparam int unsigned MAX_CYCLES = 2 * N_RETIRE + 20;  // a retire takes two cycles at most
    localparam logic [31:0] SEED       = 32'hdef37c98;

    logic        clk;
    logic        rst_n;
    logic [63:0] fetch_addr;
    logic [31:0] inst;
    retire_t     retire;
    int unsigned n_retired;

    `include "ref_model.svh"

    rv_core #(.XLEN(64), .RESET_PC(RESET_PC)) u_rv_core (
        .clk          (clk       ),
        .rst_n        (rst_n     ),
        .fetch_addr_o (fetch_addr),
        .inst_i       (inst      ),
        .retire_o     (retire    )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset is active high
    initial begin
        rst_n = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b0;
    end

    // instruction memory, one cycle read latency
    initial begin
        inst = NOP_WORD;
        forever begin
            @(posedge clk);
            inst <= mem_word(fetch_addr);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s at retire %0d: expected %h, actual %h",
                     name, n_retired, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch against the reference model");
        end
    endtask

    // ************************************************************************
    // compare against the reference, sampled at the falling edge
    // ************************************************************************
    initial begin : compare_proc
        retire_t exp;
        bit      redirect;
        bit      squash_next;
        lcg_state   = SEED;
        n_retired   = 0;
        squash_next = 1'b0;
        fill_program();
        reset_model();
        @(negedge clk);
        while (rst_n) begin
            check_value("valid_in_reset", 64'd0, 64'(retire.valid));
            @(negedge clk);
        end
        check_value("valid_after_reset", 64'd0, 64'(retire.valid));
        while (n_retired < N_RETIRE) begin
            @(negedge clk);
            if (squash_next) begin
                check_value("squashed_slot", 64'd0, 64'(retire.valid)); // word behind a redirect
                squash_next = 1'b0;
            end else begin
                check_value("retire_valid", 64'd1, 64'(retire.valid));
                exp = ref_step(mem_word(ref_pc), redirect);
                check_value("pc", exp.pc, retire.pc);
                check_value("inst", 64'(exp.inst), 64'(retire.inst));
                check_value("rd_we", 64'(exp.rd_we), 64'(retire.rd_we));
                if (exp.rd_we) begin
                    check_value("rd", 64'(exp.rd), 64'(retire.rd));
                    check_value("rd_wdata", exp.rd_wdata, retire.rd_wdata);
                end
                squash_next = redirect;
                n_retired++;
            end
        end
        $display("Finished with no errors");
        $finish;
    end

    initial begin : timeout_proc
        int unsigned cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: %0d of %0d instructions retired after %0d cycles",
                 n_retired, N_RETIRE, cycles);
        $display("Finished with errors");
        $fatal(1, "simulation ran out of cycles");
    end

endmodule

/* logic/rv_core.sv */
module rv_core import core_pkg::*; #(
    parameter int unsigned     XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic [XLEN-1:0]   fetch_addr_o,
    input  logic [INST_W-1:0] inst_i,
    output retire_t           retire_o
);

    logic [XLEN-1:0]       exec_pc;
    logic                  exec_valid;
    logic [REG_ADDR_W-1:0] raddr1;        // decode -> regfile
    logic [REG_ADDR_W-1:0] raddr2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    exec_ctrl_t            exec_ctrl;
    wb_ctrl_t              wb_ctrl;
    csr_ctrl_t             csr_ctrl;
    redirect_t             jump;
    redirect_t             trap;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       csr_rdata;     // old csr value for rd

    inst_fetch #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_fetch (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .jump_i       (jump        ),
        .trap_i       (trap        ),
        .fetch_addr_o (fetch_addr_o),
        .exec_pc_o    (exec_pc     ),
        .exec_valid_o (exec_valid  )
    );

    inst_decode #(.XLEN(XLEN)) u_decode (
        .inst_i   (inst_i    ),
        .pc_i     (exec_pc   ),
        .valid_i  (exec_valid),
        .raddr1_o (raddr1    ),
        .raddr2_o (raddr2    ),
        .rdata1_i (rdata1    ),
        .rdata2_i (rdata2    ),
        .exec_o   (exec_ctrl ),
        .wb_o     (wb_ctrl   ),
        .csr_o    (csr_ctrl  ),
        .jump_o   (jump      )
    );

    alu_exec #(.XLEN(XLEN)) u_alu (
        .ctrl_i   (exec_ctrl ),
        .result_o (alu_result)
    );

    csr_unit #(.XLEN(XLEN)) u_csr (
        .clk     (clk      ),
        .rst_n   (rst_n    ),
        .pc_i    (exec_pc  ),
        .ctrl_i  (csr_ctrl ),
        .rdata_o (csr_rdata),
        .trap_o  (trap     )
    );

    write_back #(.XLEN(XLEN)) u_wb (
        .clk      (clk       ),
        .rst_n    (rst_n     ),
        .ctrl_i   (wb_ctrl   ),
        .alu_i    (alu_result),
        .csr_i    (csr_rdata ),
        .pc_i     (exec_pc   ),
        .inst_i   (inst_i    ),
        .valid_i  (exec_valid),
        .raddr1_i (raddr1    ),
        .raddr2_i (raddr2    ),
        .rdata1_o (rdata1    ),
        .rdata2_o (rdata2    ),
        .retire_o (retire_o  )
    );

endmodule

/* logic/write_back.sv */
module write_back import core_pkg::*; #(
    parameter int unsigned XLEN = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_ctrl_t              ctrl_i,
    input  logic [XLEN-1:0]       alu_i,
    input  logic [XLEN-1:0]       csr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic                  valid_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    output retire_t               retire_o
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] wb_data;
    logic            rd_we;

    // write-back source select
    always_comb begin
        case (ctrl_i.src)
            WB_CSR:  wb_data = csr_i;
            WB_LINK: wb_data = pc_i + XLEN'(4);
            default: wb_data = alu_i;
        endcase
    end

    assign rd_we = ctrl_i.we && (ctrl_i.rd != '0); // x0 is never written

    // ************************************************************************
    // register file with two combinational read ports
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we) begin
            regs[ctrl_i.rd] <= wb_data;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // trace for difftest
    always_comb begin
        retire_o.valid    = valid_i;
        retire_o.pc       = pc_i;
        retire_o.inst     = inst_i;
        retire_o.rd_we    = rd_we;
        retire_o.rd       = ctrl_i.rd;
        retire_o.rd_wdata = wb_data;
    end

endmodule

/* logic/csr_unit.sv */
module csr_unit import core_pkg::*; #(
    parameter int unsigned XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] pc_i,
    input  csr_ctrl_t       ctrl_i,
    output logic [XLEN-1:0] rdata_o,
    output redirect_t       trap_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    // old value for csrrw, unknown addresses read as zero
    always_comb begin
        case (ctrl_i.addr)
            CSR_MSTATUS: rdata_o = mstatus;
            CSR_MTVEC:   rdata_o = mtvec;
            CSR_MEPC:    rdata_o = mepc;
            CSR_MCAUSE:  rdata_o = mcause;
            default:     rdata_o = '0;
        endcase
    end

    // ************************************************************************
    // csr update
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (ctrl_i.is_ecall) begin
            mepc   <= pc_i;          // pc of the ecall itself
            mcause <= CAUSE_ECALL_M;
        end else if (ctrl_i.we) begin
            case (ctrl_i.addr)
                CSR_MSTATUS: mstatus <= ctrl_i.wdata;
                CSR_MTVEC:   mtvec   <= ctrl_i.wdata;
                CSR_MEPC:    mepc    <= ctrl_i.wdata;
                CSR_MCAUSE:  mcause  <= ctrl_i.wdata;
                default: ;   // write dropped
            endcase
        end
    end

    // trap entry, mtvec taken as a direct base
    assign trap_o.taken  = ctrl_i.is_ecall;
    assign trap_o.target = mtvec;

endmodule

/* execute/alu_exec.sv */
module alu_exec import core_pkg::*; #(
    parameter int unsigned XLEN = 64
) (
    input  exec_ctrl_t      ctrl_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    assign op_a = ctrl_i.op_a;
    assign op_b = ctrl_i.op_b;

    // ************************************************************************
    // integer ops, all wrap at XLEN
    // ************************************************************************
    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD: begin
                result_o = op_a + op_b;
            end
            ALU_SUB: begin
                result_o = op_a - op_b;
            end
            ALU_AND: begin
                result_o = op_a & op_b;
            end
            ALU_OR: begin
                result_o = op_a | op_b;
            end
            ALU_XOR: begin
                result_o = op_a ^ op_b;
            end
            ALU_PASS_B: begin
                result_o = op_b;   // lui immediate already shifted
            end
            default: begin
                result_o = '0;     // unused encodings
            end
        endcase
    end

endmodule

/* decode/inst_decode.sv */
module inst_decode import core_pkg::*; #(
    parameter int unsigned XLEN = 64
) (
    input  logic [INST_W-1:0]     inst_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  valid_i,
    output logic [REG_ADDR_W-1:0] raddr1_o,
    output logic [REG_ADDR_W-1:0] raddr2_o,
    input  logic [XLEN-1:0]       rdata1_i,
    input  logic [XLEN-1:0]       rdata2_i,
    output exec_ctrl_t            exec_o,
    output wb_ctrl_t              wb_o,
    output csr_ctrl_t             csr_o,
    output redirect_t             jump_o
);

    // ************************************************************************
    // field extraction
    // ************************************************************************
    logic [6:0]            opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    assign raddr1_o = inst_i[19:15];
    assign raddr2_o = inst_i[24:20];

    // enables before valid gating
    logic rd_we;
    logic csr_we;
    logic ecall;
    logic jal;

    // ************************************************************************
    // opcode / funct decode
    // ************************************************************************
    always_comb begin
        exec_o.alu_op = ALU_ADD;
        exec_o.op_a   = rdata1_i;
        exec_o.op_b   = rdata2_i;
        wb_o.src      = WB_ALU;
        rd_we         = 1'b0;
        csr_we        = 1'b0;
        ecall         = 1'b0;
        jal           = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                exec_o.op_b = imm_i;
                rd_we       = 1'b1;
                case (funct3)
                    3'b000:  exec_o.alu_op = ALU_ADD; // addi
                    3'b100:  exec_o.alu_op = ALU_XOR;
                    3'b110:  exec_o.alu_op = ALU_OR;
                    3'b111:  exec_o.alu_op = ALU_AND;
                    default: rd_we = 1'b0;            // slti, shifts etc. not here
                endcase
            end
            OPC_OP: begin
                rd_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: exec_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: exec_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: exec_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: exec_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: exec_o.alu_op = ALU_AND;
                    default:              rd_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                exec_o.alu_op = ALU_PASS_B;
                exec_o.op_b   = imm_u;
                rd_we         = 1'b1;
            end
            OPC_JAL: begin
                wb_o.src = WB_LINK;
                rd_we    = 1'b1;
                jal      = 1'b1;
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) begin // csrrw
                    wb_o.src = WB_CSR;
                    rd_we    = 1'b1;
                    csr_we   = 1'b1;
                end else if (inst_i[31:7] == '0) begin
                    ecall = 1'b1;
                end
            end
            default: ; // retires as a no-op
        endcase
    end

    // nothing leaves decode enabled for a squashed or empty slot
    assign wb_o.we        = valid_i && rd_we;
    assign wb_o.rd        = rd;
    assign csr_o.we       = valid_i && csr_we;
    assign csr_o.is_ecall = valid_i && ecall;
    assign csr_o.addr     = inst_i[31:20];
    assign csr_o.wdata    = rdata1_i;
    assign jump_o.taken   = valid_i && jal;
    assign jump_o.target  = pc_i + imm_j;

endmodule

/* logic/inst_fetch.sv */
module inst_fetch import core_pkg::*; #(
    parameter int unsigned     XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  redirect_t       jump_i,
    input  redirect_t       trap_i,
    output logic [XLEN-1:0] fetch_addr_o,
    output logic [XLEN-1:0] exec_pc_o,
    output logic            exec_valid_o
);

    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] exec_pc;
    logic            exec_valid;

    // pc of the word the memory is fetching now, and of the word in execute
    always_ff @(posedge clk) begin
        if (rst_n) begin
            fetch_pc   <= RESET_PC;
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= !(trap_i.taken || jump_i.taken); // squash in-flight word
            if (trap_i.taken) begin
                fetch_pc <= trap_i.target;
            end else if (jump_i.taken) begin
                fetch_pc <= jump_i.target;
            end else begin
                fetch_pc <= fetch_pc + XLEN'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        exec_pc <= fetch_pc; // follows the memory latency
    end

    assign fetch_addr_o = fetch_pc;
    assign exec_pc_o    = exec_pc;
    assign exec_valid_o = exec_valid;

endmodule

/* common/core_pkg.sv */
package core_pkg;

    // ************************************************************************
    // widths
    // ************************************************************************
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned CSR_ADDR_W = 12;
    localparam int unsigned INST_W     = 32;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // machine mode csrs, only these four exist
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    localparam logic [63:0] CAUSE_ECALL_M = 64'd11; // ecall from m-mode

    // ************************************************************************
    // control bundles between stages
    // ************************************************************************
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_CSR,     // old csr value
        WB_LINK     // pc + 4
    } wb_src_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [63:0] op_a;
        logic [63:0] op_b;
    } exec_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        wb_src_e               src;
    } wb_ctrl_t;

    typedef struct packed {
        logic                  we;       // csrrw
        logic                  is_ecall;
        logic [CSR_ADDR_W-1:0] addr;
        logic [63:0]           wdata;    // rs1 value
    } csr_ctrl_t;

    typedef struct packed {
        logic        taken;
        logic [63:0] target;
    } redirect_t;

    // one retired instruction, for difftest
    typedef struct packed {
        logic                  valid;
        logic [63:0]           pc;
        logic [INST_W-1:0]     inst;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [63:0]           rd_wdata;
    } retire_t;

endpackage
